// File: logic/img_capture_config.svh
`ifndef IMG_CAPTURE_CONFIG_SVH
`define IMG_CAPTURE_CONFIG_SVH

// Header words sent ahead of every image
`define IMG_HEADER_WORDS 8

// Camera pixel and stream word widths
`define IMG_PIXEL_BITS 12
`define IMG_WORD_BITS 16

// Highlight/shadow counter width
`define IMG_STAT_BITS 18

// Words written per capture
`define IMG_COUNT_BITS 24

// Default word buffer depth
`define IMG_FIFO_DEPTH 64

`endif

// File: logic/capture_ctrl_pkg.sv
`include "img_capture_config.svh"

// ======================================================================
// Command and status types
// ======================================================================
package capture_ctrl_pkg;

    // Full header, first stream word in the top 16 bits
    typedef logic [`IMG_HEADER_WORDS*`IMG_WORD_BITS-1:0] header_t;

    // Frames to drop before the captured one
    typedef logic [0:0] skip_t;

    typedef logic [`IMG_COUNT_BITS-1:0] word_count_t;
    typedef logic [`IMG_STAT_BITS-1:0] stat_count_t;

    // Command handshake FSM
    typedef enum logic [1:0] {
        DEC_IDLE,
        DEC_CAPTURING,
        DEC_ACKED
    } decoder_state_t;

endpackage

// File: logic/pixel_data_pkg.sv
`include "img_capture_config.svh"

// ======================================================================
// Pixel path types
// ======================================================================
package pixel_data_pkg;

    typedef logic [`IMG_PIXEL_BITS-1:0] pixel_t;
    typedef logic [`IMG_WORD_BITS-1:0] word_t;

    // Fletcher-32, sum2 on top
    typedef logic [2*`IMG_WORD_BITS-1:0] checksum_t;

    // Frame sequencing FSM
    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_HEADER,
        SEQ_WAIT_FRAME_END,
        SEQ_WAIT_FRAME_START,
        SEQ_PIXELS,
        SEQ_CHECKSUM_LO,
        SEQ_CHECKSUM_HI
    } seq_state_t;

endpackage

// File: logic/capture_cmd_decoder.sv
`timescale 1ns/10ps

module capture_cmd_decoder (
    input  logic                      clk,
    input  logic                      readout_rst,
    input  logic                      cmd_req,
    input  capture_ctrl_pkg::header_t cmd_header,
    input  capture_ctrl_pkg::skip_t   cmd_skip,
    input  logic                      seq_done,
    output logic                      cmd_ack,
    output logic                      seq_start,
    output capture_ctrl_pkg::header_t seq_header,
    output capture_ctrl_pkg::skip_t   seq_skip
);

    capture_ctrl_pkg::decoder_state_t state;

    // Command payload, captured as the request is accepted
    always_ff @(posedge clk) begin
        if (state == capture_ctrl_pkg::DEC_IDLE && cmd_req) begin
            seq_header <= cmd_header;
            seq_skip   <= cmd_skip;
        end
    end

    // ==================================================================
    // Four-phase command FSM
    // ==================================================================
    always_ff @(posedge clk) begin
        if (!readout_rst) begin
            state     <= capture_ctrl_pkg::DEC_IDLE;
            cmd_ack   <= 1'b0;
            seq_start <= 1'b0;
        end else begin
            seq_start <= 1'b0;
            case (state)
                capture_ctrl_pkg::DEC_IDLE: begin
                    if (cmd_req) begin
                        seq_start <= 1'b1;
                        state     <= capture_ctrl_pkg::DEC_CAPTURING;
                    end
                end
                capture_ctrl_pkg::DEC_CAPTURING: begin
                    // Last checksum word is in the buffer
                    if (seq_done) begin
                        cmd_ack <= 1'b1;
                        state   <= capture_ctrl_pkg::DEC_ACKED;
                    end
                end
                capture_ctrl_pkg::DEC_ACKED: begin
                    // Requester must release before a new capture
                    if (!cmd_req) begin
                        cmd_ack <= 1'b0;
                        state   <= capture_ctrl_pkg::DEC_IDLE;
                    end
                end
                default: state <= capture_ctrl_pkg::DEC_IDLE;
            endcase
        end
    end

endmodule

// File: logic/fletcher_checksum.sv
`timescale 1ns/10ps
`include "img_capture_config.svh"

module fletcher_checksum (
    input  logic                      clk,
    input  logic                      readout_rst,
    input  logic                      clear,
    input  logic                      en,
    input  pixel_data_pkg::word_t     din,
    output pixel_data_pkg::checksum_t sum
);

    pixel_data_pkg::word_t sum1;
    pixel_data_pkg::word_t sum2;
    pixel_data_pkg::word_t sum1_next;

    // Addition modulo 65535
    function automatic pixel_data_pkg::word_t add_mod(input pixel_data_pkg::word_t a,
                                                      input pixel_data_pkg::word_t b);
        logic [`IMG_WORD_BITS:0] s;
        s = {1'b0, a} + {1'b0, b};
        if (s >= {1'b0, {`IMG_WORD_BITS{1'b1}}})
            s = s - {1'b0, {`IMG_WORD_BITS{1'b1}}};
        add_mod = s[`IMG_WORD_BITS-1:0];
    endfunction

    assign sum1_next = add_mod(sum1, din);
    assign sum = {sum2, sum1};

    always_ff @(posedge clk) begin
        if (!readout_rst || clear) begin
            sum1 <= '0;
            sum2 <= '0;
        end else if (en) begin
            sum1 <= sum1_next;
            sum2 <= add_mod(sum2, sum1_next);
        end
    end

endmodule

// File: logic/frame_sequencer.sv
`timescale 1ns/10ps
`include "img_capture_config.svh"

module frame_sequencer (
    input  logic                      clk,
    input  logic                      readout_rst,
    input  logic                      seq_start,
    input  capture_ctrl_pkg::header_t seq_header,
    input  capture_ctrl_pkg::skip_t   seq_skip,
    input  pixel_data_pkg::pixel_t    img_d,
    input  logic                      img_fv,
    input  logic                      img_lv,
    output logic                      wr_valid,
    output pixel_data_pkg::word_t     wr_data,
    output logic                      stat_valid,
    output pixel_data_pkg::pixel_t    stat_pixel,
    output logic                      seq_done
);

    localparam int HDR_CNT_BITS = $clog2(`IMG_HEADER_WORDS);
    localparam int HDR_BITS = $bits(capture_ctrl_pkg::header_t);

    pixel_data_pkg::seq_state_t state;
    capture_ctrl_pkg::header_t  hdr_shift;
    logic [HDR_CNT_BITS-1:0]    hdr_left;
    capture_ctrl_pkg::skip_t    skip_left;

    pixel_data_pkg::pixel_t     d_q;
    logic                       fv_q;
    logic                       lv_q;
    logic                       lv_prev;
    logic [1:0]                 col;
    logic [1:0]                 row;

    logic                       sum_en;
    pixel_data_pkg::checksum_t  sum;

    function automatic pixel_data_pkg::word_t swap_bytes(input pixel_data_pkg::word_t w);
        swap_bytes = {w[7:0], w[15:8]};
    endfunction

    // Checksum sees little-endian words, like the host does
    fletcher_checksum u_checksum (
        .clk         (clk),
        .readout_rst (readout_rst),
        .clear       (seq_start),
        .en          (sum_en),
        .din         (swap_bytes(wr_data)),
        .sum         (sum)
    );

    // ==================================================================
    // Camera input registers and tile position
    // ==================================================================
    always_ff @(posedge clk) begin
        d_q <= img_d;
    end

    always_ff @(posedge clk) begin
        if (!readout_rst) begin
            fv_q    <= 1'b0;
            lv_q    <= 1'b0;
            lv_prev <= 1'b0;
            col     <= 2'd0;
            row     <= 2'd0;
        end else begin
            fv_q    <= img_fv;
            lv_q    <= img_lv;
            lv_prev <= lv_q;
            if (!lv_q) col <= 2'd0;
            else       col <= col + 2'd1;
            // Next row on every end of line
            if (!fv_q)                row <= 2'd0;
            else if (lv_prev && !lv_q) row <= row + 2'd1;
        end
    end

    // ==================================================================
    // Sequencing FSM
    // ==================================================================
    always_ff @(posedge clk) begin
        if (!readout_rst) begin
            state      <= pixel_data_pkg::SEQ_IDLE;
            wr_valid   <= 1'b0;
            sum_en     <= 1'b0;
            stat_valid <= 1'b0;
            seq_done   <= 1'b0;
            hdr_left   <= '0;
            skip_left  <= '0;
        end else begin
            wr_valid   <= 1'b0;
            sum_en     <= 1'b0;
            stat_valid <= 1'b0;
            seq_done   <= 1'b0;
            if (seq_start) begin
                // First header word goes out right away
                wr_valid  <= 1'b1;
                sum_en    <= 1'b1;
                hdr_left  <= HDR_CNT_BITS'(`IMG_HEADER_WORDS - 1);
                skip_left <= seq_skip;
                state     <= pixel_data_pkg::SEQ_HEADER;
            end else begin
                case (state)
                    pixel_data_pkg::SEQ_HEADER: begin
                        wr_valid <= 1'b1;
                        sum_en   <= 1'b1;
                        hdr_left <= hdr_left - 1'b1;
                        if (hdr_left == HDR_CNT_BITS'(1))
                            state <= pixel_data_pkg::SEQ_WAIT_FRAME_END;
                    end
                    pixel_data_pkg::SEQ_WAIT_FRAME_END: begin
                        if (!fv_q) state <= pixel_data_pkg::SEQ_WAIT_FRAME_START;
                    end
                    pixel_data_pkg::SEQ_WAIT_FRAME_START: begin
                        if (fv_q) begin
                            if (skip_left != '0) begin
                                skip_left <= skip_left - 1'b1;
                                state     <= pixel_data_pkg::SEQ_WAIT_FRAME_END;
                            end else begin
                                state <= pixel_data_pkg::SEQ_PIXELS;
                            end
                        end
                    end
                    pixel_data_pkg::SEQ_PIXELS: begin
                        wr_valid   <= lv_q;
                        sum_en     <= lv_q;
                        stat_valid <= lv_q && col == 2'd0 && row == 2'd0;
                        if (!fv_q) state <= pixel_data_pkg::SEQ_CHECKSUM_LO;
                    end
                    pixel_data_pkg::SEQ_CHECKSUM_LO: begin
                        wr_valid <= 1'b1;
                        state    <= pixel_data_pkg::SEQ_CHECKSUM_HI;
                    end
                    pixel_data_pkg::SEQ_CHECKSUM_HI: begin
                        wr_valid <= 1'b1;
                        seq_done <= 1'b1;
                        state    <= pixel_data_pkg::SEQ_IDLE;
                    end
                    default: state <= pixel_data_pkg::SEQ_IDLE;
                endcase
            end
        end
    end

    // Word payload
    always_ff @(posedge clk) begin
        stat_pixel <= d_q;
        if (seq_start) begin
            wr_data   <= seq_header[HDR_BITS-1 -: `IMG_WORD_BITS];
            hdr_shift <= seq_header << `IMG_WORD_BITS;
        end else begin
            case (state)
                pixel_data_pkg::SEQ_HEADER: begin
                    wr_data   <= hdr_shift[HDR_BITS-1 -: `IMG_WORD_BITS];
                    hdr_shift <= hdr_shift << `IMG_WORD_BITS;
                end
                pixel_data_pkg::SEQ_CHECKSUM_LO: wr_data <= swap_bytes(sum[15:0]);
                pixel_data_pkg::SEQ_CHECKSUM_HI: wr_data <= swap_bytes(sum[31:16]);
                // Low byte, then 4 zero bits and the top nibble
                default: wr_data <= {d_q[7:0], 4'b0000, d_q[11:8]};
            endcase
        end
    end

endmodule

// File: logic/pixel_stats.sv
`timescale 1ns/10ps
`include "img_capture_config.svh"

module pixel_stats (
    input  logic                        clk,
    input  logic                        readout_rst,
    input  logic                        clear,
    input  logic                        stat_valid,
    input  pixel_data_pkg::pixel_t      stat_pixel,
    output capture_ctrl_pkg::stat_count_t highlight_count,
    output capture_ctrl_pkg::stat_count_t shadow_count
);

    localparam int TOP_BITS = 7;

    logic                   sample_valid;
    pixel_data_pkg::pixel_t sample_px;
    logic [TOP_BITS-1:0]    px_top;

    // Classification looks only at the brightest bits
    assign px_top = sample_px[`IMG_PIXEL_BITS-1 -: TOP_BITS];

    always_ff @(posedge clk) begin
        sample_px <= stat_pixel;
    end

    always_ff @(posedge clk) begin
        if (!readout_rst || clear) begin
            sample_valid    <= 1'b0;
            highlight_count <= '0;
            shadow_count    <= '0;
        end else begin
            sample_valid <= stat_valid;
            if (sample_valid) begin
                if (px_top == {TOP_BITS{1'b1}})
                    highlight_count <= highlight_count + 1'b1;
                else if (px_top == '0)
                    shadow_count <= shadow_count + 1'b1;
            end
        end
    end

endmodule

// File: logic/word_emitter.sv
`timescale 1ns/10ps
`include "img_capture_config.svh"

module word_emitter #(
    parameter int FIFO_DEPTH = `IMG_FIFO_DEPTH
) (
    input  logic                          clk,
    input  logic                          readout_rst,
    input  logic                          clear,
    input  logic                          wr_valid,
    input  pixel_data_pkg::word_t         wr_data,
    input  logic                          out_ack,
    output logic                          out_req,
    output pixel_data_pkg::word_t         out_data,
    output capture_ctrl_pkg::word_count_t word_count,
    output logic                          overflow
);

    localparam int PTR_BITS = $clog2(FIFO_DEPTH);
    localparam int LVL_BITS = $clog2(FIFO_DEPTH + 1);

    pixel_data_pkg::word_t mem [FIFO_DEPTH];
    logic [PTR_BITS-1:0]   wr_ptr;
    logic [PTR_BITS-1:0]   rd_ptr;
    logic [LVL_BITS-1:0]   level;
    logic                  full;
    logic                  empty;
    logic                  push;
    logic                  pop;
    logic                  offer;

    function automatic logic [PTR_BITS-1:0] ptr_inc(input logic [PTR_BITS-1:0] p);
        ptr_inc = (p == PTR_BITS'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full  = level == LVL_BITS'(FIFO_DEPTH);
    assign empty = level == '0;
    assign push  = wr_valid && !full;
    assign pop   = out_req && out_ack;
    // New word only once the sink has dropped its ack
    assign offer = !out_req && !out_ack && !empty;

    // ==================================================================
    // Circular buffer
    // ==================================================================
    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= wr_data;
        if (offer) out_data <= mem[rd_ptr];
    end

    always_ff @(posedge clk) begin
        if (!readout_rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            level   <= '0;
            out_req <= 1'b0;
        end else begin
            if (push) wr_ptr <= ptr_inc(wr_ptr);
            if (pop)  rd_ptr <= ptr_inc(rd_ptr);
            case ({push, pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
            if (pop)        out_req <= 1'b0;
            else if (offer) out_req <= 1'b1;
        end
    end

    // Per-capture status
    always_ff @(posedge clk) begin
        if (!readout_rst || clear) begin
            word_count <= '0;
            overflow   <= 1'b0;
        end else begin
            if (push) word_count <= word_count + 1'b1;
            // Dropped word, sticky until the next capture
            if (wr_valid && full) overflow <= 1'b1;
        end
    end

endmodule

// File: logic/img_capture_top.sv
`timescale 1ns/10ps

module img_capture_top (
    input  logic                          clk,
    input  logic                          readout_rst,
    input  logic                          cmd_req,
    input  capture_ctrl_pkg::header_t     cmd_header,
    input  capture_ctrl_pkg::skip_t       cmd_skip,
    output logic                          cmd_ack,
    input  pixel_data_pkg::pixel_t        img_d,
    input  logic                          img_fv,
    input  logic                          img_lv,
    output logic                          out_req,
    output pixel_data_pkg::word_t         out_data,
    input  logic                          out_ack,
    output capture_ctrl_pkg::word_count_t status_word_count,
    output capture_ctrl_pkg::stat_count_t status_highlight_count,
    output capture_ctrl_pkg::stat_count_t status_shadow_count,
    output logic                          status_overflow
);

    logic                      seq_start;
    logic                      seq_done;
    capture_ctrl_pkg::header_t seq_header;
    capture_ctrl_pkg::skip_t   seq_skip;
    logic                      wr_valid;
    pixel_data_pkg::word_t     wr_data;
    logic                      stat_valid;
    pixel_data_pkg::pixel_t    stat_pixel;

    capture_cmd_decoder u_decoder (
        .clk         (clk),
        .readout_rst (readout_rst),
        .cmd_req     (cmd_req),
        .cmd_header  (cmd_header),
        .cmd_skip    (cmd_skip),
        .seq_done    (seq_done),
        .cmd_ack     (cmd_ack),
        .seq_start   (seq_start),
        .seq_header  (seq_header),
        .seq_skip    (seq_skip)
    );

    frame_sequencer u_sequencer (
        .clk         (clk),
        .readout_rst (readout_rst),
        .seq_start   (seq_start),
        .seq_header  (seq_header),
        .seq_skip    (seq_skip),
        .img_d       (img_d),
        .img_fv      (img_fv),
        .img_lv      (img_lv),
        .wr_valid    (wr_valid),
        .wr_data     (wr_data),
        .stat_valid  (stat_valid),
        .stat_pixel  (stat_pixel),
        .seq_done    (seq_done)
    );

    // Counts restart with each capture
    pixel_stats u_stats (
        .clk             (clk),
        .readout_rst     (readout_rst),
        .clear           (seq_start),
        .stat_valid      (stat_valid),
        .stat_pixel      (stat_pixel),
        .highlight_count (status_highlight_count),
        .shadow_count    (status_shadow_count)
    );

    word_emitter u_emitter (
        .clk         (clk),
        .readout_rst (readout_rst),
        .clear       (seq_start),
        .wr_valid    (wr_valid),
        .wr_data     (wr_data),
        .out_ack     (out_ack),
        .out_req     (out_req),
        .out_data    (out_data),
        .word_count  (status_word_count),
        .overflow    (status_overflow)
    );

endmodule

// File: sim/img_capture_properties.sv
`timescale 1ns/10ps

module img_capture_properties (
    input logic                  clk,
    input logic                  readout_rst,
    input logic                  cmd_req,
    input logic                  cmd_ack,
    input logic                  out_req,
    input logic                  out_ack,
    input pixel_data_pkg::word_t out_data,
    input logic                  status_overflow
);

    int fail_count = 0;

    // ======================================================================
    // Output four-phase handshake
    // ======================================================================
    out_data_held: assert property (@(posedge clk) disable iff (!readout_rst)
        out_req && !out_ack |=> $stable(out_data))
        else begin
            $error("out_data changed while the sink had not acknowledged");
            fail_count++;
        end

    out_req_waits_ack: assert property (@(posedge clk) disable iff (!readout_rst)
        $fell(out_req) |-> $past(out_ack))
        else begin
            $error("out_req dropped without out_ack");
            fail_count++;
        end

    // ======================================================================
    // Command handshake and status
    // ======================================================================
    cmd_ack_rise: assert property (@(posedge clk) disable iff (!readout_rst)
        $rose(cmd_ack) |-> cmd_req)
        else begin
            $error("cmd_ack rose with no request pending");
            fail_count++;
        end

    cmd_ack_fall: assert property (@(posedge clk) disable iff (!readout_rst)
        $fell(cmd_ack) |-> !$past(cmd_req))
        else begin
            $error("cmd_ack dropped while cmd_req was still high");
            fail_count++;
        end

    // Sink is always fast enough for the line blanking
    no_overflow: assert property (@(posedge clk) disable iff (!readout_rst)
        !status_overflow)
        else begin
            $error("word buffer overflowed");
            fail_count++;
        end

endmodule

bind img_capture_top img_capture_properties u_props (
    .clk             (clk),
    .readout_rst     (readout_rst),
    .cmd_req         (cmd_req),
    .cmd_ack         (cmd_ack),
    .out_req         (out_req),
    .out_ack         (out_ack),
    .out_data        (out_data),
    .status_overflow (status_overflow)
);

// File: sim/img_capture_tb.sv
`timescale 1ns/10ps
`include "img_capture_config.svh"

module img_capture_tb;

    localparam int FRAME_LINES = 8;
    localparam int LINE_PIXELS = 16;
    localparam int LINE_BLANK = 80;
    localparam int EXPECTED_WORDS = `IMG_HEADER_WORDS + FRAME_LINES * LINE_PIXELS + 2;
    // Six frames of about 820 cycles and the drain stay far below this
    localparam int TIMEOUT_CYCLES = 40000;

    logic                          clk;
    logic                          readout_rst;
    logic                          cmd_req;
    capture_ctrl_pkg::header_t     cmd_header;
    capture_ctrl_pkg::skip_t       cmd_skip;
    logic                          cmd_ack;
    pixel_data_pkg::pixel_t        img_d;
    logic                          img_fv;
    logic                          img_lv;
    logic                          out_req;
    pixel_data_pkg::word_t         out_data;
    logic                          out_ack;
    capture_ctrl_pkg::word_count_t status_word_count;
    capture_ctrl_pkg::stat_count_t status_highlight_count;
    capture_ctrl_pkg::stat_count_t status_shadow_count;
    logic                          status_overflow;

    pixel_data_pkg::pixel_t frame_px [FRAME_LINES][LINE_PIXELS];
    pixel_data_pkg::word_t  got_words [$];
    pixel_data_pkg::word_t  exp_words [$];
    int                     ack_delays [$];
    int                     exp_highlight;
    int                     exp_shadow;
    int                     cycle_count = 0;

    img_capture_top UUT (
        .clk                    (clk),
        .readout_rst            (readout_rst),
        .cmd_req                (cmd_req),
        .cmd_header             (cmd_header),
        .cmd_skip               (cmd_skip),
        .cmd_ack                (cmd_ack),
        .img_d                  (img_d),
        .img_fv                 (img_fv),
        .img_lv                 (img_lv),
        .out_req                (out_req),
        .out_data               (out_data),
        .out_ack                (out_ack),
        .status_word_count      (status_word_count),
        .status_highlight_count (status_highlight_count),
        .status_shadow_count    (status_shadow_count),
        .status_overflow        (status_overflow)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1, "Run stopped on the first error");
    endtask

    task automatic report_mismatch(input string what);
        abort_run($sformatf("CHECK FAILED at %0t ns: %s", $time, what));
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
            abort_run($sformatf("Timeout: run did not finish in %0d cycles", TIMEOUT_CYCLES));
        else if (UUT.u_props.fail_count != 0)
            abort_run("A bound protocol assertion failed");
    end

    // ======================================================================
    // Frame contents and reference stream
    // ======================================================================
    function automatic pixel_data_pkg::word_t byte_swap(input pixel_data_pkg::word_t w);
        byte_swap = {w[7:0], w[15:8]};
    endfunction

    function automatic capture_ctrl_pkg::header_t random_header();
        random_header = {$urandom, $urandom, $urandom, $urandom};
    endfunction

    task automatic fill_random_frame();
        for (int ln = 0; ln < FRAME_LINES; ln++)
            for (int c = 0; c < LINE_PIXELS; c++)
                frame_px[ln][c] = pixel_data_pkg::pixel_t'($urandom);
    endtask

    // Highlight, shadow and mid level rotate, so corners see all three
    task automatic fill_tile_pattern();
        int k;
        for (int ln = 0; ln < FRAME_LINES; ln++) begin
            for (int c = 0; c < LINE_PIXELS; c++) begin
                k = ln * LINE_PIXELS + c;
                case (k % 3)
                    0:       frame_px[ln][c] = 12'hfe0 | 12'(k % 32);
                    1:       frame_px[ln][c] = 12'(k % 32);
                    default: frame_px[ln][c] = 12'h800 | 12'(k);
                endcase
            end
        end
    endtask

    task automatic build_expected(input capture_ctrl_pkg::header_t hdr);
        int s1;
        int s2;
        pixel_data_pkg::pixel_t p;
        exp_words.delete();
        exp_highlight = 0;
        exp_shadow = 0;
        s1 = 0;
        s2 = 0;
        // Header goes out most significant word first
        for (int i = `IMG_HEADER_WORDS - 1; i >= 0; i--)
            exp_words.push_back(hdr[i*16 +: 16]);
        for (int ln = 0; ln < FRAME_LINES; ln++) begin
            for (int c = 0; c < LINE_PIXELS; c++) begin
                p = frame_px[ln][c];
                exp_words.push_back({p[7:0], 4'h0, p[11:8]});
                // Tile corners are classified by their top 7 bits
                if (ln % 4 == 0 && c % 4 == 0) begin
                    if (p[11:5] == 7'h7f)
                        exp_highlight++;
                    else if (p[11:5] == 7'h00)
                        exp_shadow++;
                end
            end
        end
        foreach (exp_words[i]) begin
            s1 = (s1 + byte_swap(exp_words[i])) % 65535;
            s2 = (s2 + s1) % 65535;
        end
        exp_words.push_back(byte_swap(s1[15:0]));
        exp_words.push_back(byte_swap(s2[15:0]));
    endtask

    // ======================================================================
    // Camera and sink models
    // ======================================================================
    task automatic send_frame();
        // Blank time lets the header finish before the frame starts
        repeat (20) @(posedge clk);
        img_fv <= 1'b1;
        repeat (10) @(posedge clk);
        for (int ln = 0; ln < FRAME_LINES; ln++) begin
            for (int c = 0; c < LINE_PIXELS; c++) begin
                img_lv <= 1'b1;
                img_d  <= frame_px[ln][c];
                @(posedge clk);
            end
            img_lv <= 1'b0;
            repeat (LINE_BLANK) @(posedge clk);
        end
        img_fv <= 1'b0;
        @(posedge clk);
    endtask

    task automatic run_sink();
        int wait_left;
        wait_left = 0;
        out_ack = 1'b0;
        forever begin
            @(posedge clk);
            if (out_req && !out_ack) begin
                if (wait_left > 0) begin
                    wait_left = wait_left - 1;
                end else begin
                    got_words.push_back(out_data);
                    out_ack <= 1'b1;
                    wait_left = (ack_delays.size() > 0) ? ack_delays.pop_front() : 0;
                end
            end else if (!out_req && out_ack) begin
                out_ack <= 1'b0;
            end
        end
    endtask

    initial run_sink();

    task automatic start_capture(input capture_ctrl_pkg::header_t hdr,
                                 input capture_ctrl_pkg::skip_t skip);
        got_words.delete();
        @(posedge clk);
        cmd_header <= hdr;
        cmd_skip   <= skip;
        cmd_req    <= 1'b1;
    endtask

    task automatic finish_capture(input capture_ctrl_pkg::header_t hdr, input int hold_cycles);
        build_expected(hdr);
        while (!cmd_ack) @(posedge clk);
        assert (status_word_count == EXPECTED_WORDS)
            else report_mismatch($sformatf("word count %0d, expected %0d",
                                           status_word_count, EXPECTED_WORDS));
        assert (status_highlight_count == exp_highlight)
            else report_mismatch($sformatf("highlight count %0d, expected %0d",
                                           status_highlight_count, exp_highlight));
        assert (status_shadow_count == exp_shadow)
            else report_mismatch($sformatf("shadow count %0d, expected %0d",
                                           status_shadow_count, exp_shadow));
        assert (!status_overflow) else report_mismatch("status_overflow set");
        // Ack stays up as long as the request does
        repeat (hold_cycles) begin
            @(posedge clk);
            assert (cmd_ack) else report_mismatch("cmd_ack fell while cmd_req was high");
        end
        cmd_req <= 1'b0;
        while (cmd_ack || got_words.size() < exp_words.size()) @(posedge clk);
        repeat (8) @(posedge clk);
        assert (got_words.size() == exp_words.size())
            else report_mismatch($sformatf("%0d words collected, expected %0d",
                                           got_words.size(), exp_words.size()));
        foreach (exp_words[i]) begin
            assert (got_words[i] == exp_words[i])
                else report_mismatch($sformatf("word %0d is %h, expected %h",
                                               i, got_words[i], exp_words[i]));
        end
    endtask

    // ======================================================================
    // Directed tests
    // ======================================================================
    task automatic test_reset_state();
        assert (!cmd_ack && !out_req && !status_overflow)
            else report_mismatch("handshake or overflow output high after reset");
        assert (status_word_count == 0 && status_highlight_count == 0 &&
                status_shadow_count == 0)
            else report_mismatch("status counts not zero after reset");
    endtask

    task automatic test_basic_capture();
        capture_ctrl_pkg::header_t hdr;
        hdr = random_header();
        fill_random_frame();
        start_capture(hdr, 1'b0);
        send_frame();
        finish_capture(hdr, 0);
    endtask

    task automatic test_skip_frame();
        capture_ctrl_pkg::header_t hdr;
        hdr = random_header();
        fill_random_frame();
        start_capture(hdr, 1'b1);
        send_frame();
        // Second frame differs and is the one expected
        fill_random_frame();
        send_frame();
        finish_capture(hdr, 0);
    endtask

    task automatic test_tile_stats();
        capture_ctrl_pkg::header_t hdr;
        hdr = random_header();
        fill_tile_pattern();
        start_capture(hdr, 1'b0);
        send_frame();
        finish_capture(hdr, 0);
    endtask

    task automatic test_random_backpressure();
        capture_ctrl_pkg::header_t hdr;
        hdr = random_header();
        repeat (200) ack_delays.push_back($urandom_range(3, 0));
        fill_random_frame();
        start_capture(hdr, 1'b0);
        send_frame();
        finish_capture(hdr, 0);
        ack_delays.delete();
    endtask

    // Counts match one frame only, so the earlier capture was cleared
    task automatic test_second_capture();
        capture_ctrl_pkg::header_t hdr;
        hdr = random_header();
        fill_tile_pattern();
        start_capture(hdr, 1'b0);
        send_frame();
        finish_capture(hdr, 5);
    endtask

    initial begin
        void'($urandom(52));
        readout_rst = 1'b0;
        cmd_req     = 1'b0;
        cmd_header  = '0;
        cmd_skip    = '0;
        img_d       = '0;
        img_fv      = 1'b0;
        img_lv      = 1'b0;
        repeat (3) @(posedge clk);
        readout_rst <= 1'b1;
        @(posedge clk);
        test_reset_state();
        test_basic_capture();
        test_skip_frame();
        test_tile_stats();
        // Follows a capture with nonzero highlight and shadow counts
        test_second_capture();
        test_random_backpressure();
        if (UUT.u_props.fail_count == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            abort_run("A bound protocol assertion failed during the run");
        end
    end

endmodule

// File: filelist.f
+incdir+logic
logic/capture_ctrl_pkg.sv
logic/pixel_data_pkg.sv
logic/capture_cmd_decoder.sv
logic/fletcher_checksum.sv
logic/frame_sequencer.sv
logic/pixel_stats.sv
logic/word_emitter.sv
logic/img_capture_top.sv
sim/img_capture_properties.sv
sim/img_capture_tb.sv
